// ==== rtl/colmix_consts.svh ====
// Width, register map and latency macros, included by the colour mixer sources
`ifndef COLMIX_CONSTS_SVH
`define COLMIX_CONSTS_SVH

// Palette RAM is 1024 bytes, two per colour
`define COLMIX_PAL_AW 10
`define COLMIX_DW 8
`define COLMIX_IDX_W 9

// APB address space
`define COLMIX_APB_AW 11

// Control registers above the palette window
`define COLMIX_REG_CTRL  11'h400
`define COLMIX_REG_BANKS 11'h401
`define COLMIX_REG_BD_LO 11'h402
`define COLMIX_REG_BD_HI 11'h403

// Clocks from pixel sample to rgb and sync_out
`define COLMIX_LATENCY 4

// Both layers on, layer 1 on top
`define COLMIX_CTRL_RESET 8'h0C

`endif

// ==== rtl/colmix_pkg.sv ====
// Shared struct and enum types for the colour mixer RTL and its testbench
package colmix_pkg;

`include "colmix_consts.svh"

    // APB request as driven by the CPU side
    typedef struct packed {
        logic [`COLMIX_APB_AW-1:0] paddr;
        logic                      psel;
        logic                      penable;
        logic                      pwrite;
        logic [`COLMIX_DW-1:0]     pwdata;
    } apb_req_t;

    // APB response back to the CPU
    typedef struct packed {
        logic [`COLMIX_DW-1:0] prdata;
        logic                  pready;
        logic                  pslverr;
    } apb_rsp_t;

    // Layer pixel codes, pen 0 is transparent
    typedef struct packed {
        logic [4:0] gfx1;       // Bit 4 picks the layer-1 sub-bank
        logic [3:0] gfx2;
    } pxl_in_t;

    // Blanking flags, active high
    typedef struct packed {
        logic hblank;
        logic vblank;
    } sync_t;

    typedef struct packed {
        logic [4:0] red;
        logic [4:0] green;
        logic [4:0] blue;
    } rgb_t;

    // Which layer wins when both are opaque
    typedef enum logic [1:0] {
        PRIO_L1_OVER   = 2'd0,
        PRIO_L2_OVER   = 2'd1,
        PRIO_PEN_SPLIT = 2'd2  // Layer 2 on top only for pens 8..15
    } prio_mode_e;

    typedef struct packed {
        prio_mode_e                 mode;
        logic                       l1_en;
        logic                       l2_en;
        logic [2:0]                 bank1;
        logic [3:0]                 bank2;
        logic [`COLMIX_IDX_W-1:0]   backdrop;
    } ctrl_t;

    // Single-cycle palette request from the register block
    typedef struct packed {
        logic [`COLMIX_PAL_AW-1:0] addr;
        logic                      we;
        logic [`COLMIX_DW-1:0]     wdata;
    } pal_cpu_t;

endpackage

// ==== rtl/colmix_regs.sv ====
// APB slave with the mixer control registers, forwards palette accesses to the RAM port
`timescale 1ns/1ps
`include "colmix_consts.svh"

module colmix_regs (
    input  logic                          clk,
    input  logic                          rst,
    input  colmix_pkg::apb_req_t          apb,
    output colmix_pkg::apb_rsp_t          apb_rsp,
    output colmix_pkg::ctrl_t             ctrl,
    output colmix_pkg::pal_cpu_t          pal_cpu,
    input  logic [`COLMIX_DW-1:0]         pal_cpu_q
);

    localparam logic [7:0] CTRL_RST = `COLMIX_CTRL_RESET;

    // Palette reads need one wait state for the registered RAM output
    typedef enum logic {
        ACC_FIRST,
        ACC_RD_WAIT
    } acc_state_e;

    acc_state_e state;
    logic       access;
    logic       pal_sel;
    logic       reg_sel;
    logic       pal_rd;
    logic       done;
    logic [7:0] reg_rdata;

    // Second phase of the APB transfer
    assign access  = apb.psel & apb.penable;
    // Bottom 1 KiB is the palette
    assign pal_sel = ~apb.paddr[10];
    assign reg_sel = apb.paddr inside {`COLMIX_REG_CTRL, `COLMIX_REG_BANKS,
                                       `COLMIX_REG_BD_LO, `COLMIX_REG_BD_HI};
    assign pal_rd  = pal_sel & ~apb.pwrite;
    // Everything but a palette read completes in its first access cycle
    assign done    = access & (~pal_rd | (state == ACC_RD_WAIT));

    // RAM request straight from the bus, write strobe only once
    assign pal_cpu.addr  = apb.paddr[`COLMIX_PAL_AW-1:0];
    assign pal_cpu.we    = access & pal_sel & apb.pwrite;
    assign pal_cpu.wdata = apb.pwdata;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ACC_FIRST;
        end else if (state == ACC_FIRST && access && pal_rd) begin
            state <= ACC_RD_WAIT;
        end else if (state == ACC_RD_WAIT) begin
            state <= ACC_FIRST;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ctrl.mode     <= colmix_pkg::prio_mode_e'(CTRL_RST[1:0]);
            ctrl.l1_en    <= CTRL_RST[2];
            ctrl.l2_en    <= CTRL_RST[3];
            ctrl.bank1    <= '0;
            ctrl.bank2    <= '0;
            ctrl.backdrop <= '0;
        end else if (access && reg_sel && apb.pwrite) begin
            case (apb.paddr)
                `COLMIX_REG_CTRL: begin
                    ctrl.mode  <= colmix_pkg::prio_mode_e'(apb.pwdata[1:0]);
                    ctrl.l1_en <= apb.pwdata[2];
                    ctrl.l2_en <= apb.pwdata[3];
                end
                `COLMIX_REG_BANKS: begin
                    ctrl.bank1 <= apb.pwdata[2:0];
                    ctrl.bank2 <= apb.pwdata[7:4];
                end
                `COLMIX_REG_BD_LO: ctrl.backdrop[7:0] <= apb.pwdata;
                default: ctrl.backdrop[8] <= apb.pwdata[0];
            endcase
        end
    end

    // Read-back with unused bits at zero
    always_comb begin
        case (apb.paddr)
            `COLMIX_REG_CTRL:  reg_rdata = {4'b0, ctrl.l2_en, ctrl.l1_en, ctrl.mode};
            `COLMIX_REG_BANKS: reg_rdata = {ctrl.bank2, 1'b0, ctrl.bank1};
            `COLMIX_REG_BD_LO: reg_rdata = ctrl.backdrop[7:0];
            `COLMIX_REG_BD_HI: reg_rdata = {7'b0, ctrl.backdrop[8]};
            default:           reg_rdata = 8'h00;
        endcase
    end

    assign apb_rsp.prdata  = pal_sel ? pal_cpu_q : reg_rdata;
    assign apb_rsp.pready  = done;
    // Holes in the map fail at once
    assign apb_rsp.pslverr = access & ~pal_sel & ~reg_sel;

    // Setup phase must come before every access phase
    a_apb_setup: assert property (@(posedge clk) disable iff (rst)
        $rose(apb.penable) |-> $past(apb.psel));

endmodule

// ==== rtl/colmix_pal_ram.sv ====
// Dual-port palette RAM, CPU read/write port and video read port, both registered
`timescale 1ns/1ps
`include "colmix_consts.svh"

module colmix_pal_ram (
    input  logic                          clk,
    input  colmix_pkg::pal_cpu_t          pal_cpu,
    output logic [`COLMIX_DW-1:0]         pal_cpu_q,
    input  logic [`COLMIX_PAL_AW-1:0]     vid_addr,
    output logic [`COLMIX_DW-1:0]         vid_q
);

    localparam int DEPTH = 1 << `COLMIX_PAL_AW;

    // Contents come from the CPU only
    logic [`COLMIX_DW-1:0] mem [DEPTH];

    // CPU port, old data on the read side when writing
    always_ff @(posedge clk) begin
        if (pal_cpu.we) begin
            mem[pal_cpu.addr] <= pal_cpu.wdata;
        end
        pal_cpu_q <= mem[pal_cpu.addr];
    end

    // Video port
    // Sees the old byte on a same-cycle CPU write
    always_ff @(posedge clk) begin
        vid_q <= mem[vid_addr];
    end

endmodule

// ==== rtl/colmix_prio.sv ====
// Layer priority and transparency, registers the 9-bit colour index per pixel
`timescale 1ns/1ps
`include "colmix_consts.svh"

module colmix_prio (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          pxl_cen,
    input  colmix_pkg::pxl_in_t           pxl,
    input  colmix_pkg::ctrl_t             ctrl,
    output logic [`COLMIX_IDX_W-1:0]      col_idx
);

    logic                     l1_opaque;
    logic                     l2_opaque;
    logic                     l2_wins;
    logic [`COLMIX_IDX_W-1:0] l1_idx;
    logic [`COLMIX_IDX_W-1:0] l2_idx;
    logic [`COLMIX_IDX_W-1:0] idx_next;

    // Disabled layer behaves like pen 0
    assign l1_opaque = ctrl.l1_en && (pxl.gfx1[3:0] != 4'h0);
    assign l2_opaque = ctrl.l2_en && (pxl.gfx2 != 4'h0);

    // Upper half of the palette for layer 1
    assign l1_idx = {1'b1, ctrl.bank1, pxl.gfx1[4], pxl.gfx1[3:0]};
    // Lower half for layer 2
    assign l2_idx = {1'b0, ctrl.bank2, pxl.gfx2};

    // Tie-break when both layers show
    always_comb begin
        case (ctrl.mode)
            colmix_pkg::PRIO_L1_OVER:   l2_wins = 1'b0;
            colmix_pkg::PRIO_L2_OVER:   l2_wins = 1'b1;
            // Bright half of layer 2 pens goes on top
            colmix_pkg::PRIO_PEN_SPLIT: l2_wins = pxl.gfx2[3];
            default:                    l2_wins = 1'b0;
        endcase
    end

    always_comb begin
        if (l1_opaque && l2_opaque) begin
            idx_next = l2_wins ? l2_idx : l1_idx;
        end else if (l1_opaque) begin
            idx_next = l1_idx;
        end else if (l2_opaque) begin
            idx_next = l2_idx;
        end else begin
            // Nothing drawn here
            idx_next = ctrl.backdrop;
        end
    end

    // One index per pixel enable
    always_ff @(posedge clk) begin
        if (rst) begin
            col_idx <= '0;
        end else if (pxl_cen) begin
            col_idx <= idx_next;
        end
    end

endmodule

// ==== rtl/colmix_fetch.sv ====
// Reads the two palette bytes of each colour index and assembles the 15-bit RGB
`timescale 1ns/1ps
`include "colmix_consts.svh"

module colmix_fetch (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          pxl_cen,
    input  logic [`COLMIX_IDX_W-1:0]      col_idx,
    output logic [`COLMIX_PAL_AW-1:0]     vid_addr,
    input  logic [`COLMIX_DW-1:0]         vid_q,
    output colmix_pkg::rgb_t              rgb
);

    // Byte select, 0 for low byte in the cycle after the enable
    logic       half;
    // Byte select of the data now on vid_q
    logic       half_q;
    logic [7:0] lo_byte;

    assign vid_addr = {col_idx, half};

    always_ff @(posedge clk) begin
        if (rst) begin
            half   <= 1'b1;
            half_q <= 1'b1;
            rgb    <= '0;
        end else begin
            // Realign on every enable
            half   <= pxl_cen ? 1'b0 : ~half;
            half_q <= half;
            // High byte arrived, lo_byte holds its partner
            if (half_q) begin
                rgb.red   <= lo_byte[4:0];
                rgb.green <= {vid_q[1:0], lo_byte[7:5]};
                // Bit 7 of the high byte is spare
                rgb.blue  <= vid_q[6:2];
            end
        end
    end

    // Low byte waits one clock for the high byte
    always_ff @(posedge clk) begin
        if (!half_q) begin
            lo_byte <= vid_q;
        end
    end

    // Two reads per pixel need the enable at half rate
    a_cen_rate: assert property (@(posedge clk) disable iff (rst)
        pxl_cen |=> !pxl_cen);

endmodule

// ==== rtl/colmix_blank.sv ====
// Delays the sync flags to match the pixel pipeline and blacks out blanked pixels
`timescale 1ns/1ps
`include "colmix_consts.svh"

module colmix_blank (
    input  logic                          clk,
    input  logic                          rst,
    input  colmix_pkg::sync_t             sync_in,
    input  colmix_pkg::rgb_t              rgb_in,
    output colmix_pkg::sync_t             sync_out,
    output colmix_pkg::rgb_t              rgb
);

    // Flags of the pixel now leaving the fetch block sit in the last stage
    colmix_pkg::sync_t dly [`COLMIX_LATENCY];

    always_ff @(posedge clk) begin
        if (rst) begin
            // Start out blanked
            for (int i = 0; i < `COLMIX_LATENCY; i++) begin
                dly[i] <= '1;
            end
            sync_out <= '1;
            rgb      <= '0;
        end else begin
            dly[0] <= sync_in;
            for (int i = 1; i < `COLMIX_LATENCY; i++) begin
                dly[i] <= dly[i-1];
            end
            sync_out <= dly[`COLMIX_LATENCY-1];
            // Black in either blanking interval
            if (dly[`COLMIX_LATENCY-1].hblank || dly[`COLMIX_LATENCY-1].vblank) begin
                rgb <= '0;
            end else begin
                rgb <= rgb_in;
            end
        end
    end

endmodule

// ==== rtl/colmix_top.sv ====
// Colour mixer top level, tile layer codes and APB palette access in, blanked RGB out
`timescale 1ns/1ps
`include "colmix_consts.svh"

module colmix_top (
    input  logic                     clk,
    input  logic                     rst,
    input  colmix_pkg::apb_req_t     apb,
    output colmix_pkg::apb_rsp_t     apb_rsp,
    input  logic                     pxl_cen,
    input  colmix_pkg::pxl_in_t      pxl,
    input  colmix_pkg::sync_t        sync_in,
    output colmix_pkg::rgb_t         rgb,
    output colmix_pkg::sync_t        sync_out
);

    colmix_pkg::ctrl_t               ctrl;
    colmix_pkg::pal_cpu_t            pal_cpu;
    logic [`COLMIX_DW-1:0]           pal_cpu_q;
    logic [`COLMIX_IDX_W-1:0]        col_idx;
    logic [`COLMIX_PAL_AW-1:0]       vid_addr;
    logic [`COLMIX_DW-1:0]           vid_q;
    // Unblanked colour from the fetch stage
    colmix_pkg::rgb_t                rgb_raw;

    // CPU side
    colmix_regs i_regs (
        .clk       (clk),
        .rst       (rst),
        .apb       (apb),
        .apb_rsp   (apb_rsp),
        .ctrl      (ctrl),
        .pal_cpu   (pal_cpu),
        .pal_cpu_q (pal_cpu_q)
    );

    colmix_pal_ram i_pal_ram (
        .clk       (clk),
        .pal_cpu   (pal_cpu),
        .pal_cpu_q (pal_cpu_q),
        .vid_addr  (vid_addr),
        .vid_q     (vid_q)
    );

    // Video pipeline, index then fetch then blanking
    colmix_prio i_prio (
        .clk       (clk),
        .rst       (rst),
        .pxl_cen   (pxl_cen),
        .pxl       (pxl),
        .ctrl      (ctrl),
        .col_idx   (col_idx)
    );

    colmix_fetch i_fetch (
        .clk       (clk),
        .rst       (rst),
        .pxl_cen   (pxl_cen),
        .col_idx   (col_idx),
        .vid_addr  (vid_addr),
        .vid_q     (vid_q),
        .rgb       (rgb_raw)
    );

    colmix_blank i_blank (
        .clk       (clk),
        .rst       (rst),
        .sync_in   (sync_in),
        .rgb_in    (rgb_raw),
        .sync_out  (sync_out),
        .rgb       (rgb)
    );

endmodule

// ==== test/colmix_tb_tasks.svh ====
// APB tasks, LFSR stimulus, palette model and compare tasks, included inside the testbench module
`ifndef COLMIX_TB_TASKS_SVH
`define COLMIX_TB_TASKS_SVH

    // Galois LFSR, polynomial x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // One LFSR step per bit
    task automatic random_byte(output logic [7:0] b);
        b = '0;
        for (int i = 0; i < 8; i++) begin
            lfsr = lfsr_next(lfsr);
            b = {b[6:0], lfsr[0]};
        end
    endtask

    // Setup cycle, then access cycles until pready
    task automatic apb_xfer(input logic [10:0] addr, input logic wr, input logic [7:0] wdata,
                            output logic [7:0] rdata, output logic slverr);
        bit got;
        got    = 1'b0;
        rdata  = '0;
        slverr = 1'b0;
        @(negedge clk);
        apb.paddr   = addr;
        apb.pwrite  = wr;
        apb.pwdata  = wdata;
        apb.psel    = 1'b1;
        apb.penable = 1'b0;
        @(negedge clk);
        apb.penable = 1'b1;
        // Response sampled at the edge that ends the access cycle
        for (int n = 0; n < APB_TIMEOUT && !got; n++) begin
            @(posedge clk);
            if (apb_rsp.pready) begin
                got    = 1'b1;
                rdata  = apb_rsp.prdata;
                slverr = apb_rsp.pslverr;
            end
        end
        @(negedge clk);
        apb.psel    = 1'b0;
        apb.penable = 1'b0;
        if (!got) begin
            errors++;
            $display("APB transfer to address 0x%h never saw pready", addr);
        end
    endtask

    task automatic apb_write(input logic [10:0] addr, input logic [7:0] wdata,
                             output logic slverr);
        logic [7:0] unused;
        apb_xfer(addr, 1'b1, wdata, unused, slverr);
    endtask

    task automatic apb_read(input logic [10:0] addr, output logic [7:0] rdata,
                            output logic slverr);
        apb_xfer(addr, 1'b0, 8'h00, rdata, slverr);
    endtask

    task automatic compare_rgb(input string name, input colmix_pkg::rgb_t got,
                               input colmix_pkg::rgb_t exp);
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    task automatic compare_sync(input string name, input colmix_pkg::sync_t got,
                                input colmix_pkg::sync_t exp);
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    task automatic compare_byte(input string name, input logic [7:0] got,
                                input logic [7:0] exp);
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    task automatic compare_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    task automatic read_check(input logic [10:0] addr, input logic [7:0] exp,
                              input string name);
        logic [7:0] rd;
        logic       err;
        apb_read(addr, rd, err);
        compare_flag("pslverr", err, 1'b0);
        compare_byte(name, rd, exp);
    endtask

    task automatic write_read_check(input logic [10:0] addr, input logic [7:0] wdata,
                                    input logic [7:0] exp, input string name);
        logic err;
        apb_write(addr, wdata, err);
        compare_flag("pslverr", err, 1'b0);
        read_check(addr, exp, name);
    endtask

    // Colour index straight from the register bytes and the layer codes
    function automatic logic [8:0] model_index(input stim_t s);
        logic       l1_show;
        logic       l2_show;
        logic [8:0] l1_idx;
        logic [8:0] l2_idx;
        logic [8:0] idx;
        // Pen 0 or a switched-off layer shows nothing
        l1_show = s.ctrl_b[2] && (s.pxl.gfx1[3:0] != 4'h0);
        l2_show = s.ctrl_b[3] && (s.pxl.gfx2 != 4'h0);
        l1_idx  = {1'b1, s.banks_b[2:0], s.pxl.gfx1};
        l2_idx  = {1'b0, s.banks_b[7:4], s.pxl.gfx2};
        if (!l1_show && !l2_show) begin
            idx = s.bd;
        end else if (!l2_show) begin
            idx = l1_idx;
        end else if (!l1_show) begin
            idx = l2_idx;
        end else if (s.ctrl_b[1:0] == 2'd1) begin
            idx = l2_idx;
        end else if (s.ctrl_b[1:0] == 2'd2 && s.pxl.gfx2 >= 4'd8) begin
            idx = l2_idx;
        end else begin
            idx = l1_idx;
        end
        return idx;
    endfunction

    // Two bytes per colour, low byte at the even address
    function automatic colmix_pkg::rgb_t model_rgb(input logic [8:0] idx);
        logic [7:0]       lo;
        logic [7:0]       hi;
        colmix_pkg::rgb_t c;
        lo      = pal_model[{idx, 1'b0}];
        hi      = pal_model[{idx, 1'b1}];
        c.red   = lo[4:0];
        c.green = {hi[1:0], lo[7:5]};
        c.blue  = hi[6:2];
        return c;
    endfunction

    task automatic add_row(input string name, input logic [7:0] ctrl_b,
                           input logic [7:0] banks_b, input logic [8:0] bd,
                           input logic [4:0] gfx1, input logic [3:0] gfx2,
                           input logic [1:0] sync);
        stim_t s;
        s.ctrl_b   = ctrl_b;
        s.banks_b  = banks_b;
        s.bd       = bd;
        s.pxl.gfx1 = gfx1;
        s.pxl.gfx2 = gfx2;
        s.sync     = sync;
        rows.push_back(s);
        row_names.push_back(name);
    endtask

    task automatic finish_test(input string name, input int err_start);
        tests_run++;
        if (errors == err_start) begin
            $display("[PASS] %s", name);
        end else begin
            tests_failed++;
            $display("[FAIL] %s, %0d mismatches", name, errors - err_start);
        end
    endtask

`endif

// ==== test/colmix_tb.sv ====
// Testbench for the colour mixer that runs APB register and palette checks and then the pixel table
`timescale 1ns/1ps
`include "colmix_consts.svh"

module colmix_tb;

    localparam int APB_TIMEOUT = 20;

    // One row of the pixel table with register bytes and the pixel itself
    typedef struct packed {
        logic [7:0]          ctrl_b;
        logic [7:0]          banks_b;
        logic [8:0]          bd;
        colmix_pkg::pxl_in_t pxl;
        colmix_pkg::sync_t   sync;
    } stim_t;

    logic                 clk;
    logic                 rst;
    colmix_pkg::apb_req_t apb;
    colmix_pkg::apb_rsp_t apb_rsp;
    logic                 pxl_cen;
    colmix_pkg::pxl_in_t  pxl;
    colmix_pkg::sync_t    sync_in;
    colmix_pkg::rgb_t     rgb;
    colmix_pkg::sync_t    sync_out;

    // Shadow of the palette with the spare bit 7 of high bytes kept
    logic [7:0]  pal_model [1024];
    logic [31:0] lfsr;
    int          errors;
    int          tests_run;
    int          tests_failed;
    stim_t       rows [$];
    string       row_names [$];

    colmix_top i_dut (
        .clk      (clk),
        .rst      (rst),
        .apb      (apb),
        .apb_rsp  (apb_rsp),
        .pxl_cen  (pxl_cen),
        .pxl      (pxl),
        .sync_in  (sync_in),
        .rgb      (rgb),
        .sync_out (sync_out)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    `include "colmix_tb_tasks.svh"

    // Presents one pixel for a single enable and then drains it to the outputs
    task automatic apply_pixel(input colmix_pkg::pxl_in_t p, input colmix_pkg::sync_t s);
        @(negedge clk);
        pxl     = p;
        sync_in = s;
        pxl_cen = 1'b1;
        // Enable stays at half rate while the pixel drains
        for (int k = 1; k <= `COLMIX_LATENCY + 1; k++) begin
            @(negedge clk);
            // Other codes from here on so a wrong delay shows up
            pxl     = ~p;
            sync_in = ~s;
            pxl_cen = (k % 2 == 0);
        end
    endtask

    initial begin : main
        logic [7:0]       rd;
        logic [7:0]       wd;
        logic             err;
        colmix_pkg::rgb_t exp_rgb;
        int               err_start;

        rst          = 1'b1;
        apb          = '0;
        pxl_cen      = 1'b0;
        pxl          = '0;
        sync_in      = '0;
        lfsr         = 32'hf8ff_9385;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        repeat (10) @(negedge clk);
        rst = 1'b0;

        // Outputs blanked and registers at reset values
        err_start = errors;
        compare_rgb("rgb", rgb, '0);
        compare_sync("sync_out", sync_out, 2'b11);
        read_check(`COLMIX_REG_CTRL, `COLMIX_CTRL_RESET, "CTRL");
        read_check(`COLMIX_REG_BANKS, 8'h00, "BANKS");
        read_check(`COLMIX_REG_BD_LO, 8'h00, "BD_LO");
        read_check(`COLMIX_REG_BD_HI, 8'h00, "BD_HI");
        finish_test("register reset values", err_start);

        // Unused bits read back as zero
        err_start = errors;
        write_read_check(`COLMIX_REG_CTRL, 8'hFF, 8'h0F, "CTRL");
        write_read_check(`COLMIX_REG_BANKS, 8'hFF, 8'hF7, "BANKS");
        write_read_check(`COLMIX_REG_BD_LO, 8'hA5, 8'hA5, "BD_LO");
        write_read_check(`COLMIX_REG_BD_HI, 8'hFF, 8'h01, "BD_HI");
        finish_test("register write and read-back", err_start);

        // Holes above the register block
        err_start = errors;
        apb_write(11'h404, 8'h00, err);
        compare_flag("pslverr", err, 1'b1);
        apb_read(11'h7FF, rd, err);
        compare_flag("pslverr", err, 1'b1);
        read_check(`COLMIX_REG_CTRL, 8'h0F, "CTRL");
        finish_test("unmapped address error", err_start);

        err_start = errors;
        for (int a = 0; a < 1024; a++) begin
            random_byte(wd);
            pal_model[a] = wd;
            apb_write(a[10:0], wd, err);
        end
        for (int a = 0; a < 1024; a++) begin
            apb_read(a[10:0], rd, err);
            compare_byte("prdata", rd, pal_model[a]);
        end
        finish_test("palette fill and read-back", err_start);

        // name, CTRL, BANKS, backdrop, gfx1, gfx2, {hblank, vblank}
        add_row("prio l1_over both opaque", 8'h0C, 8'h52, 9'h1A5, 5'h07, 4'h3, 2'b00);
        add_row("prio l1_over l1 clear", 8'h0C, 8'h52, 9'h1A5, 5'h10, 4'h9, 2'b00);
        add_row("prio l2_over both opaque", 8'h0D, 8'h52, 9'h1A5, 5'h1F, 4'h4, 2'b00);
        add_row("prio l2_over l2 clear", 8'h0D, 8'h52, 9'h1A5, 5'h0B, 4'h0, 2'b00);
        add_row("prio split low pen", 8'h0E, 8'h52, 9'h1A5, 5'h05, 4'h7, 2'b00);
        add_row("prio split high pen", 8'h0E, 8'h52, 9'h1A5, 5'h05, 4'h8, 2'b00);
        add_row("prio backdrop", 8'h0E, 8'h52, 9'h1A5, 5'h10, 4'h0, 2'b00);
        add_row("bank l1 sub-bank", 8'h0C, 8'hF7, 9'h000, 5'h1C, 4'h2, 2'b00);
        add_row("bank l2", 8'h0D, 8'hA3, 9'h000, 5'h0C, 4'hE, 2'b00);
        add_row("enable l1 off", 8'h08, 8'h61, 9'h055, 5'h05, 4'h6, 2'b00);
        add_row("enable l2 off", 8'h05, 8'h61, 9'h055, 5'h05, 4'h6, 2'b00);
        add_row("enable both off", 8'h00, 8'h61, 9'h0FF, 5'h05, 4'h6, 2'b00);
        add_row("backdrop bit 8", 8'h0C, 8'h00, 9'h133, 5'h00, 4'h0, 2'b00);
        add_row("blank hblank", 8'h0C, 8'h52, 9'h1A5, 5'h07, 4'h3, 2'b10);
        add_row("blank vblank", 8'h0D, 8'h52, 9'h1A5, 5'h07, 4'h3, 2'b01);
        add_row("blank both", 8'h0C, 8'h52, 9'h1A5, 5'h00, 4'h0, 2'b11);
        add_row("blank released", 8'h0C, 8'h34, 9'h1A5, 5'h19, 4'h1, 2'b00);

        foreach (rows[r]) begin
            err_start = errors;
            apb_write(`COLMIX_REG_CTRL, rows[r].ctrl_b, err);
            apb_write(`COLMIX_REG_BANKS, rows[r].banks_b, err);
            apb_write(`COLMIX_REG_BD_LO, rows[r].bd[7:0], err);
            apb_write(`COLMIX_REG_BD_HI, {7'b0, rows[r].bd[8]}, err);
            if (rows[r].sync.hblank || rows[r].sync.vblank) begin
                exp_rgb = '0;
            end else begin
                exp_rgb = model_rgb(model_index(rows[r]));
            end
            apply_pixel(rows[r].pxl, rows[r].sync);
            compare_rgb("rgb", rgb, exp_rgb);
            compare_sync("sync_out", sync_out, rows[r].sync);
            finish_test(row_names[r], err_start);
        end

        $display("Tests run: %0d, tests failed: %0d, mismatches: %0d",
                 tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// ==== project.f ====
+incdir+rtl
+incdir+test
rtl/colmix_pkg.sv
rtl/colmix_regs.sv
rtl/colmix_pal_ram.sv
rtl/colmix_prio.sv
rtl/colmix_fetch.sv
rtl/colmix_blank.sv
rtl/colmix_top.sv
test/colmix_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= colmix_tb
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= Everything OK

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
